/* Makefile */
VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FILELIST  ?= issue_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/issue_data_pkg.sv */
package issue_data_pkg;

    // Width of an integer register and of every operand.
    localparam int DATA_WIDTH = 32;

    // Number of integer registers, x0 included.
    localparam int NUM_REGS = 32;

    localparam int REG_ADDR_WIDTH = $clog2(NUM_REGS);

    // Register and operand value.
    typedef logic [DATA_WIDTH-1:0] data_word_t;

    // Register index, x0 to x31.
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

endpackage : issue_data_pkg

/* common/issue_ops_pkg.sv */
package issue_ops_pkg;

    // Number of execution units fed by the issue stage.
    localparam int NUM_UNITS = 3;

    // Credits each unit grants after reset.
    localparam int UNIT_CREDITS = 2;

    localparam int CREDIT_WIDTH = $clog2(UNIT_CREDITS + 1);

    // Counter wide enough for the full credit count.
    typedef logic [CREDIT_WIDTH-1:0] credit_cnt_t;

    // Destination unit of an instruction, also the index into the credit counters.
    typedef enum logic [1:0] {
        ALU = 2'd0,
        MEM = 2'd1,
        FMA = 2'd2
    } exu_sel_t;

    // Where operands 1 and 2 come from.
    typedef enum logic {
        REGISTER  = 1'b0,
        IMMEDIATE = 1'b1
    } operand_src_t;

endpackage : issue_ops_pkg

/* hw/issue_register_file.sv */
`timescale 1ns/1ps

module issue_register_file (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  issue_data_pkg::reg_addr_t  rd_addr_1_i,
    input  issue_data_pkg::reg_addr_t  rd_addr_2_i,
    input  logic                       wr_en_i,
    input  issue_data_pkg::reg_addr_t  wr_addr_i,
    input  issue_data_pkg::data_word_t wr_data_i,
    output issue_data_pkg::data_word_t rd_data_1_o,
    output issue_data_pkg::data_word_t rd_data_2_o
);
    import issue_data_pkg::*;

    data_word_t regs_q [1:NUM_REGS-1];  // x0 has no storage.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // A write in the same cycle wins over the stored value.
    always_comb begin
        if (rd_addr_1_i == '0) begin
            rd_data_1_o = '0;
        end else if (wr_en_i && (wr_addr_i == rd_addr_1_i)) begin
            rd_data_1_o = wr_data_i;
        end else begin
            rd_data_1_o = regs_q[rd_addr_1_i];
        end
    end

    always_comb begin
        if (rd_addr_2_i == '0) begin
            rd_data_2_o = '0;
        end else if (wr_en_i && (wr_addr_i == rd_addr_2_i)) begin
            rd_data_2_o = wr_data_i;
        end else begin
            rd_data_2_o = regs_q[rd_addr_2_i];
        end
    end

endmodule : issue_register_file

/* hw/operand_select.sv */
`timescale 1ns/1ps

module operand_select (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        accept_i,
    input  logic                        latch_first_i,
    input  logic                        read_third_i,
    input  issue_data_pkg::data_word_t  rd_data_1_i,
    input  issue_data_pkg::data_word_t  rd_data_2_i,
    input  issue_ops_pkg::operand_src_t op_src_1_i,
    input  issue_ops_pkg::operand_src_t op_src_2_i,
    input  issue_data_pkg::data_word_t  imm_1_i,
    input  issue_data_pkg::data_word_t  imm_2_i,
    input  issue_data_pkg::reg_addr_t   dest_reg_i,
    input  issue_ops_pkg::exu_sel_t     unit_sel_i,
    output logic                        issue_valid_o,
    output issue_ops_pkg::exu_sel_t     issue_unit_o,
    output issue_data_pkg::data_word_t  operand_1_o,
    output issue_data_pkg::data_word_t  operand_2_o,
    output issue_data_pkg::data_word_t  operand_3_o,
    output issue_data_pkg::data_word_t  address_o,
    output issue_data_pkg::reg_addr_t   issue_dest_o
);
    import issue_data_pkg::*;
    import issue_ops_pkg::*;

    data_word_t src_1, src_2;           // Register or immediate, first phase.
    data_word_t held_1_q, held_2_q;     // Operands kept while operand 3 is read.
    data_word_t op_1, op_2, op_3;
    data_word_t address;

    assign src_1 = (op_src_1_i == IMMEDIATE) ? imm_1_i : rd_data_1_i;
    assign src_2 = (op_src_2_i == IMMEDIATE) ? imm_2_i : rd_data_2_i;

    // Port 1 carries src 3 during the second phase, so operands 1 and 2
    // must come from the copies taken when the state machine left IDLE.
    always_ff @(posedge clk_i) begin
        if (latch_first_i) begin
            held_1_q <= src_1;
            held_2_q <= src_2;
        end
    end

    always_comb begin
        if (read_third_i) begin
            op_1 = held_1_q;
            op_2 = held_2_q;
            op_3 = rd_data_1_i;  // Third source arrives on port 1.
        end else begin
            op_1 = src_1;
            op_2 = src_2;
            op_3 = '0;
        end
    end

    assign address = op_1 + imm_2_i;  // Memory or branch target.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= accept_i;
        end
    end

    // The issue payload loads when an instruction is accepted.
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            operand_1_o  <= op_1;
            operand_2_o  <= op_2;
            operand_3_o  <= op_3;
            address_o    <= address;
            issue_dest_o <= dest_reg_i;
            issue_unit_o <= unit_sel_i;
        end
    end

endmodule : operand_select

/* issue/issue_scheduler.sv */
`timescale 1ns/1ps

module issue_scheduler (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  logic                      uses_third_i,
    input  logic                      unit_credit_i,
    input  issue_data_pkg::reg_addr_t src_reg_1_i,
    input  issue_data_pkg::reg_addr_t src_reg_3_i,
    output logic                      stall_o,
    output logic                      accept_o,
    output logic                      latch_first_o,
    output logic                      read_third_o,
    output issue_data_pkg::reg_addr_t rd_addr_1_o
);
    import issue_data_pkg::*;

    typedef enum logic {
        IDLE,
        READ_THIRD
    } sched_state_t;

    sched_state_t state_q, state_d;

    logic in_idle;
    logic no_credit;

    assign in_idle   = (state_q == IDLE);
    assign no_credit = !unit_credit_i;

    // A three-operand instruction spends its IDLE cycle on the first read.
    assign stall_o = valid_i && (no_credit || (in_idle && uses_third_i));

    assign accept_o      = valid_i && !stall_o;  // Also consumes a credit.
    assign latch_first_o = valid_i && unit_credit_i && in_idle && uses_third_i;
    assign read_third_o  = (state_q == READ_THIRD);

    // Port 1 is shared between source 1 and source 3.
    assign rd_addr_1_o = read_third_o ? src_reg_3_i : src_reg_1_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (latch_first_o) begin
                    state_d = READ_THIRD;  // Operands 1 and 2 get latched now.
                end
            end
            READ_THIRD: begin
                if (accept_o) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule : issue_scheduler

/* issue/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   valid_i,
    input  issue_data_pkg::reg_addr_t              src_reg_1_i,
    input  issue_data_pkg::reg_addr_t              src_reg_2_i,
    input  issue_data_pkg::reg_addr_t              src_reg_3_i,
    input  logic                                   uses_third_i,
    input  issue_ops_pkg::operand_src_t            op_src_1_i,
    input  issue_ops_pkg::operand_src_t            op_src_2_i,
    input  issue_data_pkg::data_word_t             imm_1_i,
    input  issue_data_pkg::data_word_t             imm_2_i,
    input  issue_data_pkg::reg_addr_t              dest_reg_i,
    input  issue_ops_pkg::exu_sel_t                unit_sel_i,
    input  logic                                   wb_valid_i,
    input  issue_data_pkg::reg_addr_t              wb_addr_i,
    input  issue_data_pkg::data_word_t             wb_data_i,
    input  logic [issue_ops_pkg::NUM_UNITS-1:0]    credit_return_i,
    output logic                                   stall_o,
    output logic                                   issue_valid_o,
    output issue_ops_pkg::exu_sel_t                issue_unit_o,
    output issue_data_pkg::data_word_t             operand_1_o,
    output issue_data_pkg::data_word_t             operand_2_o,
    output issue_data_pkg::data_word_t             operand_3_o,
    output issue_data_pkg::data_word_t             address_o,
    output issue_data_pkg::reg_addr_t              issue_dest_o
);
    import issue_data_pkg::*;
    import issue_ops_pkg::*;

    reg_addr_t            rd_addr_1;
    data_word_t           rd_data_1, rd_data_2;
    logic                 accept, latch_first, read_third;
    logic [NUM_UNITS-1:0] has_credit;
    logic                 sel_credit;

    // Credit of the unit the current instruction is heading to.
    always_comb begin
        case (unit_sel_i)
            ALU:     sel_credit = has_credit[0];
            MEM:     sel_credit = has_credit[1];
            FMA:     sel_credit = has_credit[2];
            default: sel_credit = 1'b0;  // Unused encoding never issues.
        endcase
    end

    issue_register_file u_regfile (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rd_addr_1_i (rd_addr_1),
        .rd_addr_2_i (src_reg_2_i),
        .wr_en_i     (wb_valid_i),
        .wr_addr_i   (wb_addr_i),
        .wr_data_i   (wb_data_i),
        .rd_data_1_o (rd_data_1),
        .rd_data_2_o (rd_data_2)
    );

    issue_scheduler u_scheduler (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .valid_i       (valid_i),
        .uses_third_i  (uses_third_i),
        .unit_credit_i (sel_credit),
        .src_reg_1_i   (src_reg_1_i),
        .src_reg_3_i   (src_reg_3_i),
        .stall_o       (stall_o),
        .accept_o      (accept),
        .latch_first_o (latch_first),
        .read_third_o  (read_third),
        .rd_addr_1_o   (rd_addr_1)
    );

    operand_select u_operand_select (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .accept_i      (accept),
        .latch_first_i (latch_first),
        .read_third_i  (read_third),
        .rd_data_1_i   (rd_data_1),
        .rd_data_2_i   (rd_data_2),
        .op_src_1_i    (op_src_1_i),
        .op_src_2_i    (op_src_2_i),
        .imm_1_i       (imm_1_i),
        .imm_2_i       (imm_2_i),
        .dest_reg_i    (dest_reg_i),
        .unit_sel_i    (unit_sel_i),
        .issue_valid_o (issue_valid_o),
        .issue_unit_o  (issue_unit_o),
        .operand_1_o   (operand_1_o),
        .operand_2_o   (operand_2_o),
        .operand_3_o   (operand_3_o),
        .address_o     (address_o),
        .issue_dest_o  (issue_dest_o)
    );

    // One counter per unit, index equal to the unit encoding.
    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_credit
        unit_credit_counter u_credit (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .consume_i    (accept && (unit_sel_i == exu_sel_t'(u))),
            .return_i     (credit_return_i[u]),
            .has_credit_o (has_credit[u])
        );
    end

endmodule : issue_stage

/* issue/unit_credit_counter.sv */
`timescale 1ns/1ps

module unit_credit_counter (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic consume_i,
    input  logic return_i,
    output logic has_credit_o
);
    import issue_ops_pkg::*;

    credit_cnt_t count_q;  // Credits still available to this unit.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= credit_cnt_t'(UNIT_CREDITS);
        end else begin
            case ({consume_i, return_i})
                2'b10: begin
                    count_q <= count_q - credit_cnt_t'(1);
                end
                2'b01: begin
                    count_q <= count_q + credit_cnt_t'(1);
                end
                default: begin
                    count_q <= count_q;  // Idle, or a return and a consume cancel out.
                end
            endcase
        end
    end

    assign has_credit_o = (count_q != '0);

endmodule : unit_credit_counter

/* issue_unit.f */
common/issue_data_pkg.sv
common/issue_ops_pkg.sv
hw/issue_register_file.sv
hw/operand_select.sv
issue/issue_scheduler.sv
issue/unit_credit_counter.sv
issue/issue_stage.sv
test/issue_stage_tb.sv

/* test/issue_stage_tb.sv */
`timescale 1ns/1ps

module issue_stage_tb;
    import issue_data_pkg::*;
    import issue_ops_pkg::*;

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12 + 100;

    typedef struct packed {
        exu_sel_t   unit;
        reg_addr_t  dest;
        data_word_t op_1;
        data_word_t op_2;
        data_word_t op_3;
        data_word_t addr;
    } issue_rec_t;

    logic                 clk_i = 1'b0;
    logic                 rst_n_i, valid_i, uses_third_i, wb_valid_i;
    reg_addr_t            src_reg_1_i, src_reg_2_i, src_reg_3_i, dest_reg_i, wb_addr_i;
    operand_src_t         op_src_1_i, op_src_2_i;
    data_word_t           imm_1_i, imm_2_i, wb_data_i;
    exu_sel_t             unit_sel_i, issue_unit_o;
    logic [NUM_UNITS-1:0] credit_return_i;
    logic                 stall_o, issue_valid_o;
    data_word_t           operand_1_o, operand_2_o, operand_3_o, address_o;
    reg_addr_t            issue_dest_o;

    logic [31:0] lfsr_state = 32'd76;
    data_word_t  model_regs [0:NUM_REGS-1];
    int          model_credit [NUM_UNITS];
    int          issued [NUM_UNITS];
    int          returned [NUM_UNITS];
    issue_rec_t  expected_q [$];
    data_word_t  held_1, held_2;           // Model copies of operands 1 and 2 during the stall.
    logic        in_third, have_instr, expect_issue;
    int          generated, accepted;
    int          cycle_count = 0;

    issue_stage UUT (.*);

    always #5 clk_i = ~clk_i;

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h80200003;
        end
        return next;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    // A writeback in the reading cycle is seen by the read.
    function automatic data_word_t read_model_reg(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_valid_i && (wb_addr_i == addr)) begin
            return wb_data_i;
        end
        return model_regs[addr];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("The run hung before all instructions issued.");
        end
    end

    task automatic check_issue();
        issue_rec_t rec;
        int         unit;
        // Issues are counted from what the DUT presents to the units.
        if (issue_valid_o === 1'b1) begin
            unit = int'(issue_unit_o);
            if (unit < NUM_UNITS) begin
                issued[unit]++;
                if (issued[unit] > UNIT_CREDITS + returned[unit]) begin
                    abort_run("A unit received more instructions than it had credits for.");
                end
            end
        end
        check_value(32'(issue_valid_o), 32'(expect_issue), "issue_valid_o");
        if (expect_issue) begin
            rec = expected_q.pop_front();
            check_value(32'(issue_unit_o), 32'(rec.unit), "issue_unit_o");
            check_value(32'(issue_dest_o), 32'(rec.dest), "issue_dest_o");
            check_value(operand_1_o, rec.op_1, "operand_1_o");
            check_value(operand_2_o, rec.op_2, "operand_2_o");
            check_value(operand_3_o, rec.op_3, "operand_3_o");
            check_value(address_o, rec.addr, "address_o");
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] pick;
        if (!have_instr && (generated < NUM_INSTR) && (random_bits(2) != 0)) begin
            pick         = random_bits(2);
            src_reg_1_i  = reg_addr_t'(random_bits(5));
            src_reg_2_i  = reg_addr_t'(random_bits(5));
            src_reg_3_i  = reg_addr_t'(random_bits(5));
            dest_reg_i   = reg_addr_t'(random_bits(5));
            uses_third_i = (generated >= 3) && (random_bits(2) == 0);
            op_src_1_i   = operand_src_t'(random_bits(1));
            op_src_2_i   = operand_src_t'(random_bits(1));
            imm_1_i      = random_bits(32);
            imm_2_i      = random_bits(32);
            unit_sel_i   = ((generated < 3) || (pick == 3)) ? ALU : exu_sel_t'(pick[1:0]);
            have_instr   = 1'b1;
            generated++;
        end
        valid_i    = have_instr;
        wb_valid_i = (random_bits(1) != 0);
        pick       = random_bits(2);
        case (pick[1:0])  // Aim writebacks at the sources to hit forwarding.
            2'd0: wb_addr_i = reg_addr_t'(random_bits(5));
            2'd1: wb_addr_i = src_reg_1_i;
            2'd2: wb_addr_i = src_reg_2_i;
            default: wb_addr_i = src_reg_3_i;
        endcase
        wb_data_i = random_bits(32);
        for (int u = 0; u < NUM_UNITS; u++) begin
            credit_return_i[u] = (accepted >= 2) && (model_credit[u] < UNIT_CREDITS)
                                 && (random_bits(2) == 0);
        end
    endtask

    task automatic model_cycle();
        logic       credit_ok, exp_stall, accept;
        data_word_t val_1, val_2;
        issue_rec_t rec;
        credit_ok = (model_credit[int'(unit_sel_i)] != 0);
        exp_stall = valid_i && (!credit_ok || (!in_third && uses_third_i));
        check_value(32'(stall_o), 32'(exp_stall), "stall_o");
        accept = valid_i && !exp_stall;
        val_1  = (op_src_1_i == IMMEDIATE) ? imm_1_i : read_model_reg(src_reg_1_i);
        val_2  = (op_src_2_i == IMMEDIATE) ? imm_2_i : read_model_reg(src_reg_2_i);
        if (accept) begin
            rec.unit = unit_sel_i;
            rec.dest = dest_reg_i;
            rec.op_1 = in_third ? held_1 : val_1;
            rec.op_2 = in_third ? held_2 : val_2;
            rec.op_3 = in_third ? read_model_reg(src_reg_3_i) : '0;
            rec.addr = rec.op_1 + imm_2_i;
            expected_q.push_back(rec);
            in_third   = 1'b0;
            have_instr = 1'b0;
            accepted++;
        end else if (valid_i && credit_ok && uses_third_i) begin
            held_1   = val_1;  // First phase of a three-operand instruction.
            held_2   = val_2;
            in_third = 1'b1;
        end
        expect_issue = accept;
        if (wb_valid_i && (wb_addr_i != '0)) begin
            model_regs[wb_addr_i] = wb_data_i;
        end
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (credit_return_i[u]) begin
                model_credit[u]++;
                returned[u]++;
            end
            if (accept && (unit_sel_i == exu_sel_t'(u))) begin
                model_credit[u]--;
            end
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        uses_third_i = 1'b0;
        wb_valid_i = 1'b0;
        src_reg_1_i = '0;
        src_reg_2_i = '0;
        src_reg_3_i = '0;
        dest_reg_i = '0;
        wb_addr_i = '0;
        op_src_1_i = REGISTER;
        op_src_2_i = REGISTER;
        imm_1_i = '0;
        imm_2_i = '0;
        wb_data_i = '0;
        unit_sel_i = ALU;
        credit_return_i = '0;
        in_third = 1'b0;
        have_instr = 1'b0;
        expect_issue = 1'b0;
        generated = 0;
        accepted = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        for (int u = 0; u < NUM_UNITS; u++) begin
            model_credit[u] = UNIT_CREDITS;
            issued[u] = 0;
            returned[u] = 0;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        check_value(32'(issue_valid_o), 32'd0, "issue_valid_o after reset");
        while ((accepted < NUM_INSTR) || expect_issue) begin
            check_issue();
            drive_inputs();
            #1;
            model_cycle();  // Predicts the coming rising edge.
            @(negedge clk_i);
        end
        if (expected_q.size() != 0) begin
            abort_run("Expected issue results were left over at the end of the run.");
        end
        $display("Done: no errors");
        $finish;
    end

endmodule : issue_stage_tb
